//--- rtl/kbd_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Keyboard block constants: bus widths, matrix size, PIA register codes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package kbd_pkg;

    // Shared CPU / Wishbone data bus
    localparam int DATA_WIDTH     = 8;

    // Wishbone word address, covers the whole peripheral map
    localparam int WB_ADDR_WIDTH  = 17;

    // Row index bits, also the size of the matrix window
    localparam int KBD_ADDR_WIDTH = 4;

    // PET style matrix has 10 rows of 8 keys
    // Indices 10..15 are holes in the window and read as idle
    localparam int KBD_ROW_COUNT  = 10;

    // PIA register select comes from cpu_addr[1:0]
    localparam int PIA_RS_WIDTH   = 2;

    localparam logic [PIA_RS_WIDTH-1:0] PIA_PORTA = 2'd0;   // Row select output
    localparam logic [PIA_RS_WIDTH-1:0] PIA_PORTB = 2'd2;   // Column sense input

    // Pressed key pulls its bit low, so a quiet row is all ones
    localparam logic [DATA_WIDTH-1:0] KEY_ROW_IDLE = {DATA_WIDTH{1'b1}};

endpackage : kbd_pkg

//--- rtl/bus_decode.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone window decode and PIA 1 bus snooping (row select, port B read)
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module bus_decode #(
    parameter logic [kbd_pkg::WB_ADDR_WIDTH-1:0] WB_BASE = 17'h0_8000
) (
    input  logic                                 wb_clock_i,
    input  logic                                 arst_n_i,

    // Wishbone host side
    input  logic [kbd_pkg::WB_ADDR_WIDTH-1:0]    wb_addr_i,
    input  logic                                 wb_cycle_i,
    input  logic                                 wb_strobe_i,

    // Snooped CPU bus
    input  logic [kbd_pkg::PIA_RS_WIDTH-1:0]     pia1_rs_i,      // cpu_addr[1:0]
    input  logic                                 pia1_cs_i,      // From address decoder
    input  logic                                 cpu_we_i,
    input  logic                                 cpu_valid_strobe_i,
    input  logic                                 cpu_done_strobe_i,
    input  logic [kbd_pkg::DATA_WIDTH-1:0]       cpu_data_i,

    output logic                                 wb_access_o,    // Accepted access this cycle
    output logic [kbd_pkg::KBD_ADDR_WIDTH-1:0]   wb_row_o,
    output logic [kbd_pkg::KBD_ADDR_WIDTH-1:0]   sel_row_o,      // Row the CPU is scanning
    output logic                                 port_b_read_o
);
    import kbd_pkg::*;

    localparam int TAG_LSB = KBD_ADDR_WIDTH;   // Window tag sits above the row bits

    logic wb_hit;
    logic port_a_write;
    logic port_b_rd;

    // Window must be aligned to the 16 row slots
    if (WB_BASE[KBD_ADDR_WIDTH-1:0] != '0) begin : g_base_check
        $error("WB_BASE low bits must be zero");
    end

    // Upper address bits pick the matrix window
    assign wb_hit      = (wb_addr_i[WB_ADDR_WIDTH-1:TAG_LSB] == WB_BASE[WB_ADDR_WIDTH-1:TAG_LSB]);
    assign wb_access_o = wb_hit && wb_cycle_i && wb_strobe_i;
    assign wb_row_o    = wb_addr_i[KBD_ADDR_WIDTH-1:0];   // Word offset = row index

    // PIA 1 accesses that matter to the keyboard
    assign port_a_write =  cpu_we_i && pia1_cs_i && (pia1_rs_i == PIA_PORTA);
    assign port_b_rd    = !cpu_we_i && pia1_cs_i && (pia1_rs_i == PIA_PORTB);

    // Row select follows the CPU even during Wishbone traffic
    // A skipped strobe would lose the write, there is no retry on a snooped bus
    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sel_row_o <= '0;
        end else if (cpu_valid_strobe_i && port_a_write) begin
            sel_row_o <= cpu_data_i[KBD_ADDR_WIDTH-1:0];   // Low nibble selects row
        end
    end

    // Port B read window, valid strobe to done strobe
    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            port_b_read_o <= 1'b0;
        end else if (cpu_done_strobe_i) begin
            port_b_read_o <= 1'b0;                         // End of cycle wins
        end else if (cpu_valid_strobe_i) begin
            port_b_read_o <= port_b_rd;
        end
    end

    // CPU cycle must not end in the cycle the read flag comes up
    a_no_rise_on_done : assert property (
        @(posedge wb_clock_i) disable iff (!arst_n_i)
        $rose(port_b_read_o) |-> !cpu_done_strobe_i
    ) else $error("port_b_read_o rose together with the done strobe");

endmodule : bus_decode

//--- rtl/key_matrix.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Key matrix row storage, Wishbone slave port and CPU side row read stage
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module key_matrix (
    input  logic                                 wb_clock_i,
    input  logic                                 arst_n_i,

    // Wishbone, already qualified by the decoder
    input  logic                                 wb_access_i,
    input  logic [kbd_pkg::KBD_ADDR_WIDTH-1:0]   wb_row_i,
    input  logic                                 wb_we_i,
    input  logic [kbd_pkg::DATA_WIDTH-1:0]       wb_data_i,
    output logic [kbd_pkg::DATA_WIDTH-1:0]       wb_data_o,
    output logic                                 wb_ack_o,

    // CPU side row read
    input  logic [kbd_pkg::KBD_ADDR_WIDTH-1:0]   sel_row_i,
    output logic [kbd_pkg::DATA_WIDTH-1:0]       row_data_o
);
    import kbd_pkg::*;

    // One byte per row, bit low = key down
    logic [DATA_WIDTH-1:0] rows [KBD_ROW_COUNT];
    logic [DATA_WIDTH-1:0] wb_rd_value;
    logic [DATA_WIDTH-1:0] sel_rd_value;

    // Row lookup, idle value for the unused slots 10..15
    function automatic logic [DATA_WIDTH-1:0] row_lookup(
        input logic [KBD_ADDR_WIDTH-1:0] idx
    );
        logic [DATA_WIDTH-1:0] value;
        value = KEY_ROW_IDLE;
        for (int i = 0; i < KBD_ROW_COUNT; i++) begin
            if (idx == KBD_ADDR_WIDTH'(i)) begin
                value = rows[i];
            end
        end
        return value;
    endfunction

    assign wb_rd_value  = row_lookup(wb_row_i);
    assign sel_rd_value = row_lookup(sel_row_i);

    // Host writes the matrix, writes to missing rows fall through the loop
    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < KBD_ROW_COUNT; i++) begin
                rows[i] <= KEY_ROW_IDLE;                   // Nothing pressed
            end
        end else if (wb_access_i && wb_we_i) begin
            for (int i = 0; i < KBD_ROW_COUNT; i++) begin
                if (wb_row_i == KBD_ADDR_WIDTH'(i)) begin
                    rows[i] <= wb_data_i;
                end
            end
        end
    end

    // Single cycle ack for every accepted access
    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= wb_access_i;
        end
    end

    // Read data, held until the next read
    always_ff @(posedge wb_clock_i) begin
        if (wb_access_i && !wb_we_i) begin
            wb_data_o <= wb_rd_value;
        end
    end

    // First CPU pipeline stage
    // Frozen while the host owns the cycle
    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            row_data_o <= KEY_ROW_IDLE;                    // Row 0 after reset, idle
        end else if (!wb_access_i) begin
            row_data_o <= sel_rd_value;
        end
    end

    // Back to back acks need back to back accesses
    a_ack_single : assert property (
        @(posedge wb_clock_i) disable iff (!arst_n_i)
        (wb_ack_o && !wb_access_i) |=> !wb_ack_o
    ) else $error("wb_ack_o held without a new access");

endmodule : key_matrix

//--- rtl/cpu_intercept.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU bus intercept: registered row data and data output enable
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module cpu_intercept (
    input  logic                                 wb_clock_i,
    input  logic                                 arst_n_i,
    input  logic                                 wb_access_i,    // Host cycle, hold pipeline
    input  logic [kbd_pkg::DATA_WIDTH-1:0]       row_data_i,
    input  logic                                 port_b_read_i,
    output logic [kbd_pkg::DATA_WIDTH-1:0]       cpu_data_o,
    output logic                                 cpu_data_oe_o   // Overrides the real PIA
);
    import kbd_pkg::*;

    logic key_down;

    // Any cleared bit means a key in this row is held
    assign key_down = (row_data_i != KEY_ROW_IDLE);

    // Second pipeline stage, row value toward the CPU
    always_ff @(posedge wb_clock_i) begin
        if (!wb_access_i) begin
            cpu_data_o <= row_data_i;
        end
    end

    // Enable lines up with cpu_data_o
    // An idle row leaves port B to the PIA, which reads the same all ones
    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cpu_data_oe_o <= 1'b0;
        end else if (!port_b_read_i) begin
            cpu_data_oe_o <= 1'b0;       // Never drive past the CPU cycle, even when frozen
        end else if (!wb_access_i) begin
            cpu_data_oe_o <= key_down;
        end
    end

    // No bus contention outside a port B read
    a_oe_needs_read : assert property (
        @(posedge wb_clock_i) disable iff (!arst_n_i)
        !port_b_read_i |=> !cpu_data_oe_o
    ) else $error("cpu_data_oe_o high without a port B read");

endmodule : cpu_intercept

//--- rtl/keyboard.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Keyboard top: decode, matrix store and CPU intercept stages
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module keyboard #(
    parameter logic [kbd_pkg::WB_ADDR_WIDTH-1:0] WB_BASE = 17'h0_8000   // Matrix window
) (
    input  logic                                 wb_clock_i,
    input  logic                                 arst_n_i,

    // Wishbone B4 peripheral, no stall
    input  logic [kbd_pkg::WB_ADDR_WIDTH-1:0]    wb_addr_i,
    input  logic [kbd_pkg::DATA_WIDTH-1:0]       wb_data_i,
    output logic [kbd_pkg::DATA_WIDTH-1:0]       wb_data_o,
    input  logic                                 wb_we_i,
    input  logic                                 wb_cycle_i,
    input  logic                                 wb_strobe_i,
    output logic                                 wb_ack_o,

    // CPU bus, snooped
    input  logic [kbd_pkg::PIA_RS_WIDTH-1:0]     pia1_rs_i,
    input  logic                                 pia1_cs_i,
    input  logic                                 cpu_valid_strobe_i,
    input  logic                                 cpu_done_strobe_i,
    input  logic [kbd_pkg::DATA_WIDTH-1:0]       cpu_data_i,
    output logic [kbd_pkg::DATA_WIDTH-1:0]       cpu_data_o,
    output logic                                 cpu_data_oe_o,
    input  logic                                 cpu_we_i
);
    import kbd_pkg::*;

    logic                      wb_access;    // Also the CPU pipeline freeze
    logic [KBD_ADDR_WIDTH-1:0] wb_row;
    logic [KBD_ADDR_WIDTH-1:0] sel_row;
    logic                      port_b_read;
    logic [DATA_WIDTH-1:0]     row_data;

    bus_decode #(
        .WB_BASE (WB_BASE)
    ) i_decode (
        .wb_clock_i         (wb_clock_i),
        .arst_n_i           (arst_n_i),
        .wb_addr_i          (wb_addr_i),
        .wb_cycle_i         (wb_cycle_i),
        .wb_strobe_i        (wb_strobe_i),
        .pia1_rs_i          (pia1_rs_i),
        .pia1_cs_i          (pia1_cs_i),
        .cpu_we_i           (cpu_we_i),
        .cpu_valid_strobe_i (cpu_valid_strobe_i),
        .cpu_done_strobe_i  (cpu_done_strobe_i),
        .cpu_data_i         (cpu_data_i),
        .wb_access_o        (wb_access),
        .wb_row_o           (wb_row),
        .sel_row_o          (sel_row),
        .port_b_read_o      (port_b_read)
    );

    key_matrix i_matrix (
        .wb_clock_i  (wb_clock_i),
        .arst_n_i    (arst_n_i),
        .wb_access_i (wb_access),
        .wb_row_i    (wb_row),
        .wb_we_i     (wb_we_i),
        .wb_data_i   (wb_data_i),
        .wb_data_o   (wb_data_o),
        .wb_ack_o    (wb_ack_o),
        .sel_row_i   (sel_row),
        .row_data_o  (row_data)
    );

    // Two cycles from row select to cpu_data_o
    cpu_intercept i_intercept (
        .wb_clock_i    (wb_clock_i),
        .arst_n_i      (arst_n_i),
        .wb_access_i   (wb_access),
        .row_data_i    (row_data),
        .port_b_read_i (port_b_read),
        .cpu_data_o    (cpu_data_o),
        .cpu_data_oe_o (cpu_data_oe_o)
    );

endmodule : keyboard

//--- verification/tb_keyboard.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Keyboard testbench: stimulus file replay, Wishbone and CPU checks, watchdog
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module tb_keyboard;
    import kbd_pkg::*;

    localparam int    CLK_PERIOD  = 40;
    localparam int    ACK_LIMIT   = 8;      // Cycles allowed for wb_ack_o
    localparam int    LINE_CYCLES = 20;     // Watchdog budget per file line
    localparam string STIM_FILE   = "verification/keyboard_input.txt";

    logic                     wb_clock;
    logic                     arst_n;
    logic [WB_ADDR_WIDTH-1:0] wb_addr;
    logic [DATA_WIDTH-1:0]    wb_wdata;
    logic [DATA_WIDTH-1:0]    wb_rdata;
    logic                     wb_we;
    logic                     wb_cycle;
    logic                     wb_strobe;
    logic                     wb_ack;
    logic [PIA_RS_WIDTH-1:0]  pia1_rs;
    logic                     pia1_cs;
    logic                     cpu_valid;
    logic                     cpu_done;
    logic [DATA_WIDTH-1:0]    cpu_wdata;    // CPU to PIA
    logic [DATA_WIDTH-1:0]    cpu_rdata;    // Intercept toward the CPU
    logic                     cpu_oe;
    logic                     cpu_we;

    int error_count = 0;
    int check_count = 0;
    int line_total  = 0;                    // Set once, starts the watchdog

    keyboard #(
        .WB_BASE (17'h0_8000)
    ) i_dut (
        .wb_clock_i         (wb_clock),
        .arst_n_i           (arst_n),
        .wb_addr_i          (wb_addr),
        .wb_data_i          (wb_wdata),
        .wb_data_o          (wb_rdata),
        .wb_we_i            (wb_we),
        .wb_cycle_i         (wb_cycle),
        .wb_strobe_i        (wb_strobe),
        .wb_ack_o           (wb_ack),
        .pia1_rs_i          (pia1_rs),
        .pia1_cs_i          (pia1_cs),
        .cpu_valid_strobe_i (cpu_valid),
        .cpu_done_strobe_i  (cpu_done),
        .cpu_data_i         (cpu_wdata),
        .cpu_data_o         (cpu_rdata),
        .cpu_data_oe_o      (cpu_oe),
        .cpu_we_i           (cpu_we)
    );

    initial begin
        wb_clock = 1'b0;
        forever #(CLK_PERIOD / 2) wb_clock = ~wb_clock;
    end

    // Watchdog, budget scales with the stimulus length
    initial begin
        wait (line_total > 0);
        repeat (LINE_CYCLES * line_total) @(posedge wb_clock);
        $display("Watchdog expired after %0d cycles, run stopped", LINE_CYCLES * line_total);
        $display("Finished with errors");
        $finish;
    end

    task automatic check_value(input string test, input string what,
                               input logic [7:0] expected, input logic [7:0] actual);
        check_count++;
        if (expected !== actual) begin
            $display("Fail %s %s: expected %h, actual %h", test, what, expected, actual);
            error_count++;
        end
    endtask

    // Sample on falling edges until ack or the limit
    task automatic wait_for_ack(output logic got);
        int waited;
        got    = 1'b0;
        waited = 0;
        while (!got && waited < ACK_LIMIT) begin
            @(negedge wb_clock);
            waited++;
            got = wb_ack;
        end
    endtask

    // Drop the strobe, the ack must be gone one cycle later
    task automatic end_access(input string test);
        wb_cycle  = 1'b0;
        wb_strobe = 1'b0;
        wb_we     = 1'b0;
        @(negedge wb_clock);
        check_count++;
        if (wb_ack) begin
            $display("Test %s: wb_ack_o stayed high after the access ended", test);
            error_count++;
        end
    endtask

    task automatic start_access(input logic [16:0] addr, input logic we,
                                input logic [7:0] data);
        @(negedge wb_clock);
        wb_addr   = addr;
        wb_wdata  = data;
        wb_we     = we;
        wb_cycle  = 1'b1;
        wb_strobe = 1'b1;
    endtask

    task automatic wb_write_row(input string test, input logic [16:0] addr,
                                input logic [7:0] data);
        logic got;
        start_access(addr, 1'b1, data);
        wait_for_ack(got);
        check_count++;
        if (!got) begin
            $display("Test %s: no ack for the write to address %h", test, addr);
            error_count++;
        end
        end_access(test);
    endtask

    task automatic wb_read_row(input string test, input logic [16:0] addr,
                               input logic [7:0] expected);
        logic got;
        start_access(addr, 1'b0, 8'h00);
        wait_for_ack(got);
        if (got) begin
            check_value(test, "wb_data_o", expected, wb_rdata);  // Valid with the ack
        end else begin
            check_count++;
            $display("Test %s: no ack for the read of address %h", test, addr);
            error_count++;
        end
        end_access(test);
    endtask

    // Write outside the window, no ack may ever come
    task automatic wb_miss_access(input string test, input logic [16:0] addr,
                                  input logic [7:0] data);
        logic got;
        start_access(addr, 1'b1, data);
        wait_for_ack(got);
        check_count++;
        if (got) begin
            $display("Test %s: ack seen for address %h outside the window", test, addr);
            error_count++;
        end
        end_access(test);
    endtask

    // PIA 1 port A write, valid then done strobe
    task automatic cpu_row_select(input logic [7:0] data);
        @(negedge wb_clock);
        pia1_rs   = PIA_PORTA;
        pia1_cs   = 1'b1;
        cpu_we    = 1'b1;
        cpu_wdata = data;
        cpu_valid = 1'b1;
        @(negedge wb_clock);
        cpu_valid = 1'b0;
        cpu_done  = 1'b1;
        @(negedge wb_clock);
        cpu_done  = 1'b0;
        pia1_cs   = 1'b0;
        cpu_we    = 1'b0;
    endtask

    task automatic cpu_port_b_read(input string test, input logic cs, input logic we,
                                   input logic [7:0] exp_data, input logic exp_oe);
        @(negedge wb_clock);
        pia1_rs   = PIA_PORTB;
        pia1_cs   = cs;
        cpu_we    = we;
        cpu_wdata = 8'h00;
        cpu_valid = 1'b1;
        @(negedge wb_clock);
        cpu_valid = 1'b0;
        repeat (2) @(negedge wb_clock);                        // Third cycle after the strobe
        check_value(test, "cpu_data_o", exp_data, cpu_rdata);
        check_value(test, "cpu_data_oe_o", {7'd0, exp_oe}, {7'd0, cpu_oe});
        cpu_done = 1'b1;
        @(negedge wb_clock);
        cpu_done = 1'b0;
        pia1_cs  = 1'b0;
        cpu_we   = 1'b0;
        @(negedge wb_clock);
        check_value(test, "cpu_data_oe_o after done", 8'h00, {7'd0, cpu_oe});
    endtask

    initial begin
        int               fd;
        int               r;
        int               lines;
        logic             file_ok;
        string            name;
        string            op;
        logic [31:0]      f1;
        logic [31:0]      f2;
        logic [31:0]      f3;
        logic [31:0]      f4;
        logic [8*256-1:0] line_buf;

        arst_n    = 1'b0;
        wb_addr   = '0;
        wb_wdata  = '0;
        wb_we     = 1'b0;
        wb_cycle  = 1'b0;
        wb_strobe = 1'b0;
        pia1_rs   = '0;
        pia1_cs   = 1'b0;
        cpu_valid = 1'b0;
        cpu_done  = 1'b0;
        cpu_wdata = '0;
        cpu_we    = 1'b0;
        lines     = 0;

        // Line count sizes the watchdog
        fd      = $fopen(STIM_FILE, "r");
        file_ok = (fd != 0);
        if (!file_ok) begin
            $display("Cannot open the stimulus file %s", STIM_FILE);
            error_count++;
        end else begin
            while (!$feof(fd)) begin
                r = $fgets(line_buf, fd);
                if (r > 0) begin
                    lines++;
                end
            end
            $fclose(fd);
            line_total = lines;
        end

        repeat (3) @(negedge wb_clock);
        arst_n = 1'b1;
        @(negedge wb_clock);
        check_value("reset", "cpu_data_oe_o", 8'h00, {7'd0, cpu_oe});
        check_count++;
        if (wb_ack) begin
            $display("Test reset: wb_ack_o is high with no access after reset");
            error_count++;
        end

        if (file_ok) begin
            fd = $fopen(STIM_FILE, "r");
            while (!$feof(fd)) begin
                r = $fscanf(fd, "%s", name);
                if (r != 1) begin
                    break;
                end
                if (name == "#") begin
                    r = $fgets(line_buf, fd);                  // Column notes
                    continue;
                end
                r = $fscanf(fd, "%s %h %h %h %h", op, f1, f2, f3, f4);
                if (r != 5) begin
                    $display("Stimulus line for test %s has missing fields", name);
                    error_count++;
                    break;
                end
                case (op)
                    "wbwr":   wb_write_row(name, f1[16:0], f2[7:0]);
                    "wbrd":   wb_read_row(name, f1[16:0], f2[7:0]);
                    "wbmiss": wb_miss_access(name, f1[16:0], f2[7:0]);
                    "rowsel": cpu_row_select(f1[7:0]);
                    "portb":  cpu_port_b_read(name, f1[0], f2[0], f3[7:0], f4[0]);
                    default: begin
                        $display("Test %s has an unknown operation %s", name, op);
                        error_count++;
                    end
                endcase
            end
            $fclose(fd);
        end

        repeat (2) @(negedge wb_clock);
        $display("Errors: %0d of %0d checks", error_count, check_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : tb_keyboard

//--- verification/keyboard_input.txt
# test op f1 f2 f3 f4, all hex, window at 08000
# wbwr/wbmiss: addr data 0 0, wbrd: addr expect 0 0, rowsel: byte 0 0 0, portb: cs we data oe
rst_r0 wbrd 08000 ff 0 0
rst_r1 wbrd 08001 ff 0 0
rst_r2 wbrd 08002 ff 0 0
rst_r3 wbrd 08003 ff 0 0
rst_r4 wbrd 08004 ff 0 0
rst_r5 wbrd 08005 ff 0 0
rst_r6 wbrd 08006 ff 0 0
rst_r7 wbrd 08007 ff 0 0
rst_r8 wbrd 08008 ff 0 0
rst_r9 wbrd 08009 ff 0 0
rst_portb portb 1 0 ff 0
wr_r0 wbwr 08000 fe 0 0
wr_r3 wbwr 08003 7f 0 0
wr_r9 wbwr 08009 a5 0 0
wr_r5 wbwr 08005 ff 0 0
wr_r10 wbwr 0800a 00 0 0
wr_r15 wbwr 0800f 12 0 0
rd_r0 wbrd 08000 fe 0 0
rd_r3 wbrd 08003 7f 0 0
rd_r9 wbrd 08009 a5 0 0
rd_r1 wbrd 08001 ff 0 0
rd_r10 wbrd 0800a ff 0 0
rd_r15 wbrd 0800f ff 0 0
miss_next wbmiss 08013 00 0 0
miss_low wbmiss 00003 00 0 0
miss_top wbmiss 18003 00 0 0
rd_r3_miss wbrd 08003 7f 0 0
sel_r3 rowsel 03 0 0 0
pb_r3 portb 1 0 7f 1
sel_r9 rowsel 09 0 0 0
pb_r9 portb 1 0 a5 1
sel_r5 rowsel 05 0 0 0
pb_r5_idle portb 1 0 ff 0
sel_r0 rowsel 00 0 0 0
pb_r0_nocs portb 0 0 fe 0
pb_r0_write portb 1 1 fe 0
pb_r0 portb 1 0 fe 1
sel_r12 rowsel 0c 0 0 0
pb_r12 portb 1 0 ff 0
wr_r0_new wbwr 08000 bf 0 0
sel_r0_nib rowsel 10 0 0 0
pb_r0_new portb 1 0 bf 1

//--- filelist.f
rtl/kbd_pkg.sv
rtl/bus_decode.sv
rtl/key_matrix.sv
rtl/cpu_intercept.sv
rtl/keyboard.sv
verification/tb_keyboard.sv

//--- Makefile
# Verilator build, run and lint for the keyboard block

TOP = tb_keyboard

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o V$(TOP)

# Pass only when the simulation prints the pass line
run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

lint:
	verilator --lint-only --top-module keyboard \
		rtl/kbd_pkg.sv rtl/bus_decode.sv rtl/key_matrix.sv \
		rtl/cpu_intercept.sv rtl/keyboard.sv

clean:
	rm -rf obj_dir
